//--- common/otp_lc_macros.svh
// Sizes are tied together by hand, keep LC_DATA_W equal to LC_NUM_WORDS times OTP_WORD_W
`ifndef OTP_LC_MACROS_SVH
`define OTP_LC_MACROS_SVH

// Native fuse word and array geometry
`define OTP_WORD_W     16
`define OTP_NUM_WORDS  16
`define OTP_ADDR_W     4

// Life-cycle partition inside the array
`define LC_NUM_WORDS   4
`define LC_DATA_W      64
`define LC_BASE_ADDR   8

// Cycles from grant to response, at least 1
`define OTP_WRITE_LAT  2

`endif

//--- common/otp_lc_pkg.sv
// Types only; the 3-bit error encoding matches the macro response field and must not change

package otp_lc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // OTP command
  ////////////////////////////////////////////////////////////////////////////

  // One bit is enough since the link only carries single word accesses
  typedef enum logic {
    OtpRead  = 1'b0,
    OtpWrite = 1'b1
  } otp_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // Error codes
  ////////////////////////////////////////////////////////////////////////////

  // Codes returned by the macro with rvalid, and held by the LCI
  // Values 2, 4, 5 and 6 are reserved
  typedef enum logic [2:0] {
    // Access completed
    NoError              = 3'd0,
    // Address outside the fuse array
    MacroError           = 3'd1,
    // Write would clear a bit that is already programmed
    MacroWriteBlankError = 3'd3,
    // LCI locked by escalation, counter fault or an invalid state
    FsmStateError        = 3'd7
  } otp_err_e;

endpackage : otp_lc_pkg

//--- common/otp_if.sv
// Single outstanding access only; command fields must stay stable while req waits for gnt
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

interface otp_if (
  input logic clk_i
);

  import otp_lc_pkg::*;

  // Request side, driven by the controller
  logic                   req;
  otp_cmd_e               cmd;
  logic [`OTP_ADDR_W-1:0] addr;
  logic [`OTP_WORD_W-1:0] wdata;

  // Response side, driven by the macro
  logic                   gnt;
  logic                   rvalid;
  otp_err_e               err;

  // Life-cycle controller end of the link
  modport ctrl (
    input  clk_i,
    output req,
    output cmd,
    output addr,
    output wdata,
    input  gnt,
    input  rvalid,
    input  err
  );

  // Fuse macro end of the link
  modport macro (
    input  clk_i,
    input  req,
    input  cmd,
    input  addr,
    input  wdata,
    output gnt,
    output rvalid,
    output err
  );

endinterface : otp_if

//--- otp_lci/otp_word_cnt.sv
// Two-bit word index only; err_o stays high once the copies diverge until clr or reset
`timescale 1ns/1ps

module otp_word_cnt (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Clear has priority over increment
  input  logic       clr_i,
  input  logic       incr_i,
  output logic [1:0] cnt_o,
  output logic       err_o
);

  // Up copy starts at zero, down copy at all ones
  logic [1:0] up_q;
  logic [1:0] down_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      up_q   <= 2'b00;
      down_q <= 2'b11;
    end else if (clr_i) begin
      up_q   <= 2'b00;
      down_q <= 2'b11;
    end else if (incr_i) begin
      up_q   <= up_q + 2'd1;
      down_q <= down_q - 2'd1;
    end
  end

  assign cnt_o = up_q;

  // Sum of both copies is all ones exactly when down is the inverse of up
  assign err_o = (down_q != ~up_q);

endmodule : otp_word_cnt

//--- otp_lci/otp_lci.sv
// Programs the whole partition per request; any error or escalation locks it until reset
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

module otp_lci (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  // Single bit escalation forcing the terminal state
  input  logic                   escalate_en_i,
  // Level request with data held by the requester until ack
  input  logic                   lc_req_i,
  input  logic [`LC_DATA_W-1:0]  lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  output otp_lc_pkg::otp_err_e   error_o,
  output logic                   fsm_err_o,
  output logic                   lci_prog_idle_o,
  otp_if.ctrl                    otp
);

  import otp_lc_pkg::*;

  localparam logic [1:0] LastWord = 2'(`LC_NUM_WORDS - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////////////////////

  // Plain binary encoding with unused codes 5 to 7 caught by the trap branch
  typedef enum logic [2:0] {
    ResetSt     = 3'd0,
    IdleSt      = 3'd1,
    WriteSt     = 3'd2,
    WriteWaitSt = 3'd3,
    ErrorSt     = 3'd4
  } state_e;

  state_e   state_d, state_q;
  otp_err_e error_d, error_q;
  logic     cnt_clr, cnt_incr, cnt_err;
  logic [1:0] cnt;

  assign error_o = error_q;

  always_comb begin : p_fsm
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_incr        = 1'b0;
    lci_prog_idle_o = 1'b0;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;
    otp.req         = 1'b0;
    otp.cmd         = OtpRead;

    unique case (state_q)
      // Hold here until the LCI is enabled
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Ready for a transition request
      IdleSt: begin
        lci_prog_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Present one word and hold req until granted
      WriteSt: begin
        otp.req = 1'b1;
        otp.cmd = OtpWrite;
        if (otp.gnt) begin
          state_d = WriteWaitSt;
        end
      end
      // Wait for the response of the current word
      WriteWaitSt: begin
        if (otp.rvalid) begin
          // Keep the code but carry on with the remaining words
          if (otp.err != NoError) begin
            error_d = otp.err;
          end
          if (cnt == LastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any collected error fails the whole transition
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            state_d  = WriteSt;
            cnt_incr = 1'b1;
          end
        end
      end
      // Terminal state ignores all further requests
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched state register
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
    endcase

    // Escalation and counter faults win over everything above
    if (escalate_en_i || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word counter and address
  ////////////////////////////////////////////////////////////////////////////

  otp_word_cnt otp_word_cnt_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (cnt_clr),
    .incr_i (cnt_incr),
    .cnt_o  (cnt),
    .err_o  (cnt_err)
  );

  // Partition base plus word index
  assign otp.addr = `OTP_ADDR_W'(`LC_BASE_ADDR) + `OTP_ADDR_W'(cnt);

  // Split the life-cycle value into native words with the lowest word first
  logic [`LC_NUM_WORDS-1:0][`OTP_WORD_W-1:0] lc_words;

  assign lc_words  = lc_data_i;
  // Data bus is quiet while no request is pending
  assign otp.wdata = otp.req ? lc_words[cnt] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

endmodule : otp_lci

//--- verilog/otp_macro_model.sv
// Behavioural fuse array, blank at time zero and kept over reset; reads only via the test port
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

module otp_macro_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  otp_if.macro                   otp,
  // Combinational fuse read for test
  input  logic [`OTP_ADDR_W-1:0] test_addr_i,
  output logic [`OTP_WORD_W-1:0] test_rdata_o
);

  import otp_lc_pkg::*;

  localparam int unsigned LatW = $clog2(`OTP_WRITE_LAT) + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Fuse array
  ////////////////////////////////////////////////////////////////////////////

  logic [`OTP_WORD_W-1:0] fuse_q [`OTP_NUM_WORDS];

  // Blank fuses at power up
  initial begin
    for (int i = 0; i < `OTP_NUM_WORDS; i++) begin
      fuse_q[i] = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access check
  ////////////////////////////////////////////////////////////////////////////

  logic            busy_q;
  logic [LatW-1:0] lat_q;
  otp_err_e        err_d, err_q;
  logic            xfer, addr_ok, wr_ok;

  // Grant whenever nothing is in flight
  assign otp.gnt = ~busy_q;
  assign xfer    = otp.req & otp.gnt;
  assign addr_ok = int'(otp.addr) < `OTP_NUM_WORDS;

  always_comb begin : p_check
    err_d = NoError;
    wr_ok = 1'b0;
    if (!addr_ok) begin
      err_d = MacroError;
    end else if (otp.cmd == OtpWrite) begin
      // A one in the array with a zero in wdata cannot be undone
      if (|(fuse_q[otp.addr] & ~otp.wdata)) begin
        err_d = MacroWriteBlankError;
      end else begin
        wr_ok = 1'b1;
      end
    end
  end

  // Write takes effect at the grant edge
  always_ff @(posedge clk_i) begin : p_fuse
    if (xfer && wr_ok) begin
      fuse_q[otp.addr] <= otp.wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response timing
  ////////////////////////////////////////////////////////////////////////////

  // Latency counter counts down to zero, response in the zero cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lat
    if (!rst_ni) begin
      busy_q <= 1'b0;
      lat_q  <= '0;
    end else if (xfer) begin
      busy_q <= 1'b1;
      lat_q  <= LatW'(`OTP_WRITE_LAT - 1);
    end else if (busy_q) begin
      if (lat_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        lat_q <= lat_q - 1'b1;
      end
    end
  end

  // Response code captured with the grant
  always_ff @(posedge clk_i) begin : p_err
    if (xfer) begin
      err_q <= err_d;
    end
  end

  assign otp.rvalid = busy_q && (lat_q == '0);
  assign otp.err    = otp.rvalid ? err_q : NoError;

  // Out of range test addresses read as blank
  assign test_rdata_o = (int'(test_addr_i) < `OTP_NUM_WORDS) ? fuse_q[test_addr_i] : '0;

endmodule : otp_macro_model

//--- verilog/otp_lc_top.sv
// Plain ports toward the life-cycle side; fuse contents are visible only through test_addr_i
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

module otp_lc_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   lci_en_i,
  input  logic                   escalate_en_i,
  // Transition request
  input  logic                   lc_req_i,
  input  logic [`LC_DATA_W-1:0]  lc_data_i,
  output logic                   lc_ack_o,
  output logic                   lc_err_o,
  // Status
  output otp_lc_pkg::otp_err_e   error_o,
  output logic                   fsm_err_o,
  output logic                   lci_prog_idle_o,
  // Test read port
  input  logic [`OTP_ADDR_W-1:0] test_addr_i,
  output logic [`OTP_WORD_W-1:0] test_rdata_o
);

  // Link between controller and fuse macro
  otp_if otp_if_i (
    .clk_i (clk_i)
  );

  otp_lci otp_lci_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .otp             (otp_if_i.ctrl)
  );

  otp_macro_model otp_macro_model_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .otp          (otp_if_i.macro),
    .test_addr_i  (test_addr_i),
    .test_rdata_o (test_rdata_o)
  );

endmodule : otp_lc_top

//--- tb/otp_lc_asserts.sv
// Bound into otp_lci; the write-wait encoding below must follow the FSM enum in otp_lci
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

module otp_lc_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   gnt_i,
  input otp_lc_pkg::otp_cmd_e   cmd_i,
  input logic [`OTP_ADDR_W-1:0] addr_i,
  input logic [`OTP_WORD_W-1:0] wdata_i,
  input logic [2:0]             state_i,
  input logic                   lc_ack_i,
  input logic                   fsm_err_i,
  input otp_lc_pkg::otp_err_e   error_i
);

  import otp_lc_pkg::*;

  // Value of WriteWaitSt in the LCI
  localparam logic [2:0] WriteWaitSt = 3'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and output rules
  ////////////////////////////////////////////////////////////////////////////

  // Pending request keeps its fields until granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_i) |=> (req_i && $stable(cmd_i) && $stable(addr_i) && $stable(wdata_i)))
    else $error("OTP request dropped or changed before grant");

  // Ack only in write-wait and exactly one write latency after a grant
  a_ack_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lc_ack_i |-> ((state_i == WriteWaitSt) && $past(req_i && gnt_i, `OTP_WRITE_LAT)))
    else $error("lc_ack_o outside the write-wait state or off the write latency");

  a_fsm_err_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_i |=> (error_i != NoError))
    else $error("fsm_err_o not followed by an error code");

endmodule : otp_lc_asserts

bind otp_lci otp_lc_asserts otp_lc_asserts_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (otp.req),
  .gnt_i     (otp.gnt),
  .cmd_i     (otp.cmd),
  .addr_i    (otp.addr),
  .wdata_i   (otp.wdata),
  .state_i   (state_q),
  .lc_ack_i  (lc_ack_o),
  .fsm_err_i (fsm_err_o),
  .error_i   (error_o)
);

//--- tb/otp_lc_tb.sv
// Run from the project root so the vector file opens; fuses are observed only via the test port
`timescale 1ns/1ps

`include "otp_lc_macros.svh"

module otp_lc_tb;

  import otp_lc_pkg::*;

  // Cycle budget of every bounded wait
  localparam int WaitCycles = 64;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   lci_en_i;
  logic                   escalate_en_i;
  logic                   lc_req_i;
  logic [`LC_DATA_W-1:0]  lc_data_i;
  logic                   lc_ack_o;
  logic                   lc_err_o;
  otp_err_e               error_o;
  logic                   fsm_err_o;
  logic                   lci_prog_idle_o;
  logic [`OTP_ADDR_W-1:0] test_addr_i;
  logic [`OTP_WORD_W-1:0] test_rdata_o;

  // Expected fuse image starts blank like the array
  logic [`OTP_WORD_W-1:0] ref_fuse [`OTP_NUM_WORDS];

  otp_lc_top otp_lc_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .test_addr_i     (test_addr_i),
    .test_rdata_o    (test_rdata_o)
  );

  // 4 ns clock
  initial begin : p_clk
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Error: %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
  task automatic drive_edge();
    @(posedge clk_i);
    #1;
  endtask

  task automatic apply_reset();
    drive_edge();
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = 1'b0;
    lc_req_i      = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  // Walk the whole array through the test port
  task automatic compare_fuses(input string name);
    for (int a = 0; a < `OTP_NUM_WORDS; a++) begin
      drive_edge();
      test_addr_i = `OTP_ADDR_W'(a);
      @(negedge clk_i);
      check_value($sformatf("%s fuse %0d", name, a), 64'(ref_fuse[a]), 64'(test_rdata_o));
    end
  endtask

  // Write-once rule keeps a word that would lose a set bit
  task automatic update_ref(input logic [`LC_DATA_W-1:0] data);
    logic [`OTP_WORD_W-1:0] word;
    for (int i = 0; i < `LC_NUM_WORDS; i++) begin
      word = data[i*`OTP_WORD_W +: `OTP_WORD_W];
      if ((ref_fuse[`LC_BASE_ADDR + i] & ~word) == '0) begin
        ref_fuse[`LC_BASE_ADDR + i] = word;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic enable_lci(input string name, input int exp_err);
    logic seen;
    // Idle flag must stay low while disabled
    repeat (4) begin
      @(negedge clk_i);
      check_value({name, " idle before enable"}, 64'd0, 64'(lci_prog_idle_o));
    end
    drive_edge();
    lci_en_i = 1'b1;
    seen     = 1'b0;
    for (int c = 0; c < WaitCycles && !seen; c++) begin
      @(negedge clk_i);
      check_value({name, " ack"}, 64'd0, 64'(lc_ack_o));
      seen = lci_prog_idle_o;
    end
    if (!seen) abort_run($sformatf("%s: lci_prog_idle_o never went high", name));
    check_value({name, " error_o"}, 64'(exp_err), 64'(error_o));
  endtask

  task automatic program_value(input string name, input logic [`LC_DATA_W-1:0] data,
                               input int exp_lc_err, input int exp_err);
    logic got_ack;
    drive_edge();
    lc_data_i = data;
    lc_req_i  = 1'b1;
    got_ack   = 1'b0;
    for (int c = 0; c < WaitCycles && !got_ack; c++) begin
      @(negedge clk_i);
      if (lc_ack_o) begin
        got_ack = 1'b1;
        check_value({name, " lc_err_o"}, 64'(exp_lc_err), 64'(lc_err_o));
      end
    end
    if (!got_ack) abort_run($sformatf("%s: no ack from the LCI", name));
    drive_edge();
    lc_req_i = 1'b0;
    // Code and state settle one edge after the ack
    @(negedge clk_i);
    check_value({name, " error_o"}, 64'(exp_err), 64'(error_o));
    check_value({name, " idle"}, 64'(exp_lc_err == 0), 64'(lci_prog_idle_o));
    update_ref(data);
    compare_fuses(name);
  endtask

  task automatic expect_no_ack(input string name, input logic [`LC_DATA_W-1:0] data,
                               input int exp_err);
    drive_edge();
    lc_data_i = data;
    lc_req_i  = 1'b1;
    for (int c = 0; c < WaitCycles; c++) begin
      @(negedge clk_i);
      if (lc_ack_o) abort_run($sformatf("%s: locked LCI acknowledged a request", name));
      check_value({name, " idle"}, 64'd0, 64'(lci_prog_idle_o));
    end
    drive_edge();
    lc_req_i = 1'b0;
    check_value({name, " error_o"}, 64'(exp_err), 64'(error_o));
    compare_fuses(name);
  endtask

  task automatic raise_escalation(input string name, input int exp_err);
    logic seen;
    drive_edge();
    escalate_en_i = 1'b1;
    seen          = 1'b0;
    for (int c = 0; c < WaitCycles && !seen; c++) begin
      @(negedge clk_i);
      seen = fsm_err_o;
    end
    if (!seen) abort_run($sformatf("%s: fsm_err_o never went high", name));
    drive_edge();
    escalate_en_i = 1'b0;
    @(negedge clk_i);
    // Pulse is over and the code is held
    check_value({name, " fsm_err_o"}, 64'd0, 64'(fsm_err_o));
    check_value({name, " error_o"}, 64'(exp_err), 64'(error_o));
    check_value({name, " idle"}, 64'd0, 64'(lci_prog_idle_o));
  endtask

  task automatic reset_and_recheck(input string name, input int exp_err);
    apply_reset();
    @(negedge clk_i);
    check_value({name, " error_o"}, 64'(exp_err), 64'(error_o));
    check_value({name, " idle"}, 64'd0, 64'(lci_prog_idle_o));
    check_value({name, " fsm_err_o"}, 64'd0, 64'(fsm_err_o));
    // Fuses survive reset
    compare_fuses(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    int                    fd;
    int                    code;
    int                    vec_no;
    int                    vec_lc_err;
    int                    vec_err;
    string                 op;
    string                 skip_line;
    string                 name;
    logic [`LC_DATA_W-1:0] vec_data;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = 1'b0;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    test_addr_i   = '0;
    for (int a = 0; a < `OTP_NUM_WORDS; a++) begin
      ref_fuse[a] = '0;
    end
    apply_reset();
    fd = $fopen("tb/otp_lc_vectors.txt", "r");
    if (fd == 0) abort_run("Cannot open tb/otp_lc_vectors.txt");
    vec_no = 0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        // Drop the rest of a comment line
        code = $fgets(skip_line, fd);
      end else begin
        code = $fscanf(fd, "%h %d %d", vec_data, vec_lc_err, vec_err);
        if (code != 3) abort_run($sformatf("Malformed vector after operation %s", op));
        vec_no++;
        name = $sformatf("%s vector %0d", op, vec_no);
        if (op == "enable") enable_lci(name, vec_err);
        else if (op == "prog") program_value(name, vec_data, vec_lc_err, vec_err);
        else if (op == "noack") expect_no_ack(name, vec_data, vec_err);
        else if (op == "escalate") raise_escalation(name, vec_err);
        else if (op == "reset") reset_and_recheck(name, vec_err);
        else abort_run($sformatf("Unknown operation %s in the vector file", op));
      end
    end
    $fclose(fd);
    if (vec_no == 0) begin
      abort_run("Vector file holds no operations");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule : otp_lc_tb

//--- tb/otp_lc_vectors.txt
# op  data(64 bit hex, word 0 lowest)  exp_lc_err  exp_error(0 none, 3 write blank, 7 fsm)
# enable, reset and escalate ignore data; noack expects no ack within the timeout
enable   0000000000000000 0 0
prog     0001002003004000 0 0
prog     800100210b004005 0 0
prog     880100a10a00400f 1 3
noack    ffffffffffffffff 0 3
reset    0000000000000000 0 0
enable   0000000000000000 0 0
escalate 0000000000000000 0 7
noack    0123456789abcdef 0 7

//--- verilog.f
+incdir+common
common/otp_lc_pkg.sv
common/otp_if.sv
otp_lci/otp_word_cnt.sv
otp_lci/otp_lci.sv
verilog/otp_macro_model.sv
verilog/otp_lc_top.sv
tb/otp_lc_asserts.sv
tb/otp_lc_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module otp_lc_tb -o otp_lc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/otp_lc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0
